// ==== dual_issue_core.f ====
+incdir+include
verilog/issue_pkg.sv
verilog/pair_decoder.sv
verilog/wait_window.sv
verilog/issue_scoreboard.sv
verilog/reg_file.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/dual_issue_core.sv
tb/tb_dual_issue_core.sv

// ==== include/tb_ref_model.svh ====
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// program-order model state where r0 is never written
logic [31:0] model_regs [32];
logic [31:0] exp_q [32][$];

function automatic logic [31:0] encode_r(
	input logic [5:0] op,
	input logic [4:0] dd,
	input logic [4:0] ds,
	input logic [4:0] dt
);
	return {op, dd, ds, dt, 11'd0};
endfunction

function automatic logic [31:0] encode_i(
	input logic [5:0] op,
	input logic [4:0] dd,
	input logic [4:0] ds,
	input logic [15:0] imm
);
	return {op, dd, ds, imm};
endfunction

function automatic issue_pkg::fetch_pair_t make_pair(
	input logic v0,
	input logic [31:0] w0,
	input logic v1,
	input logic [31:0] w1
);
	issue_pkg::fetch_pair_t p;
	p.slot_valid[0] = v0;
	p.instr[0] = w0;
	p.slot_valid[1] = v1;
	p.instr[1] = w1;
	return p;
endfunction

function automatic int pending_writes();
	int n;
	n = 0;
	for (int i = 0; i < 32; i++) begin
		n = n + exp_q[i].size();
	end
	return n;
endfunction

// slot 0 executes before slot 1
task automatic model_pair(input issue_pkg::fetch_pair_t p);
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] r;
	logic [5:0] op;
	logic [4:0] dd;
	logic known;
	for (int s = 0; s < 2; s++) begin
		w = p.instr[s];
		op = w[31:26];
		dd = w[25:21];
		a = model_regs[w[20:16]];
		b = model_regs[w[15:11]];
		known = 1'b1;
		case (op)
			issue_pkg::op_add: r = a + b;
			issue_pkg::op_sub: r = a - b;
			issue_pkg::op_and: r = a & b;
			issue_pkg::op_or: r = a | b;
			issue_pkg::op_xor: r = a ^ b;
			issue_pkg::op_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			issue_pkg::op_addi: r = a + {{16{w[15]}}, w[15:0]};
			issue_pkg::op_mul: r = a * b;
			default: begin
				r = '0;
				known = 1'b0;
			end
		endcase
		if (p.slot_valid[s] && known && dd != 5'd0) begin
			model_regs[dd] = r;
			exp_q[dd].push_back(r);
		end
	end
endtask

// holds the pair from a falling edge until the core takes it
task automatic send_pair(input issue_pkg::fetch_pair_t p);
	int waited;
	waited = 0;
	i_pair = p;
	while (o_busy) begin
		@(negedge clk);
		waited++;
		if (waited > max_pair_cycles) begin
			abort_run("o_busy stayed high, the pair was never accepted");
		end
	end
	model_pair(p);
	@(negedge clk);
	i_pair = '0;
endtask

task automatic collect_wb(input issue_pkg::wb_t wb, input string unit_name);
	logic [31:0] exp;
	if (exp_q[wb.addr].size() == 0) begin
		abort_run($sformatf("%s unit wrote r%0d but no write to it was expected",
			unit_name, wb.addr));
	end else begin
		exp = exp_q[wb.addr].pop_front();
		check_value(wb.data, exp, $sformatf("%s write-back to r%0d", unit_name, wb.addr));
	end
endtask

`endif

// ==== tb/tb_dual_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_core;

	localparam int clk_period = 100;
	localparam int seed = 68;
	localparam int num_random_pairs = 300;
	localparam int directed_pairs = 24;
	localparam int max_pair_cycles = 40;
	localparam longint watchdog_ns =
		longint'(num_random_pairs + directed_pairs) * max_pair_cycles * clk_period;

	logic clk;
	logic rstn;
	issue_pkg::fetch_pair_t i_pair;
	logic o_busy;
	issue_pkg::wb_t o_alu_wb;
	issue_pkg::wb_t o_mul_wb;

	dual_issue_core i_dut (
		.clk(clk), .rstn(rstn), .i_pair(i_pair), .o_busy(o_busy),
		.o_alu_wb(o_alu_wb), .o_mul_wb(o_mul_wb)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(
		input logic [31:0] actual,
		input logic [31:0] expected,
		input string what
	);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
			abort_run("value mismatch");
		end
	endtask

	`include "tb_ref_model.svh"

	// every write-back is checked against its register's queue
	always @(negedge clk) begin
		if (rstn) begin
			if (o_alu_wb.valid) collect_wb(o_alu_wb, "alu");
			if (o_mul_wb.valid) collect_wb(o_mul_wb, "mul");
		end
	end

	initial begin
		#(watchdog_ns);
		abort_run("watchdog expired before the tests finished");
	end

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending_writes() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > 4 * max_pair_cycles) begin
				abort_run("expected write-backs never arrived");
			end
		end
		// catch any stray extra write
		repeat (6) @(negedge clk);
	endtask

	task automatic reset_state();
		repeat (4) begin
			check_value(o_busy, 0, "o_busy after reset");
			check_value(o_alu_wb.valid, 0, "alu wb valid after reset");
			check_value(o_mul_wb.valid, 0, "mul wb valid after reset");
			@(negedge clk);
		end
	endtask

	task automatic alu_ops();
		send_pair(make_pair(1, encode_i(issue_pkg::op_addi, 1, 0, 16'd5),
			1, encode_i(issue_pkg::op_addi, 2, 0, 16'hfffd)));
		send_pair(make_pair(1, encode_i(issue_pkg::op_addi, 3, 0, 16'h1234),
			1, encode_i(issue_pkg::op_addi, 4, 0, 16'h00f7)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_add, 6, 1, 2),
			1, encode_r(issue_pkg::op_sub, 7, 1, 2)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_and, 8, 3, 4),
			1, encode_r(issue_pkg::op_or, 9, 3, 4)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_xor, 10, 1, 3),
			1, encode_r(issue_pkg::op_slt, 11, 2, 1)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_slt, 12, 1, 2), 0, '0));
		wait_drain();
	endtask

	task automatic dependent_chain();
		send_pair(make_pair(1, encode_i(issue_pkg::op_addi, 13, 0, 16'd6),
			1, encode_i(issue_pkg::op_addi, 14, 0, 16'd7)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_mul, 15, 13, 14),
			1, encode_r(issue_pkg::op_add, 16, 15, 13)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_sub, 17, 16, 14),
			1, encode_r(issue_pkg::op_mul, 18, 16, 16)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_xor, 19, 18, 17), 0, '0));
		wait_drain();
	endtask

	task automatic write_order();
		// slow mul then fast add to the same register
		send_pair(make_pair(1, encode_r(issue_pkg::op_mul, 5, 1, 4),
			1, encode_r(issue_pkg::op_add, 5, 5, 1)));
		send_pair(make_pair(1, encode_r(issue_pkg::op_add, 20, 5, 2),
			1, encode_i(issue_pkg::op_addi, 5, 0, 16'd99)));
		wait_drain();
	endtask

	task automatic bubble_slots();
		send_pair(make_pair(1, encode_i(issue_pkg::op_addi, 21, 0, 16'd1),
			0, encode_i(issue_pkg::op_addi, 22, 0, 16'd2)));
		send_pair(make_pair(1, encode_i(issue_pkg::op_addi, 0, 0, 16'd5),
			1, encode_r(issue_pkg::op_add, 23, 1, 1)));
		send_pair(make_pair(1, encode_r(6'h3f, 24, 1, 2),
			1, encode_i(issue_pkg::op_addi, 25, 0, 16'd3)));
		wait_drain();
	endtask

	function automatic logic [31:0] random_instr();
		logic [5:0] op;
		case ($urandom_range(0, 8))
			0: op = issue_pkg::op_add;
			1: op = issue_pkg::op_sub;
			2: op = issue_pkg::op_and;
			3: op = issue_pkg::op_or;
			4: op = issue_pkg::op_xor;
			5: op = issue_pkg::op_slt;
			6: op = issue_pkg::op_addi;
			7: op = issue_pkg::op_mul;
			default: op = 6'h2a;
		endcase
		// few destinations, so hazards are frequent
		return {op, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), 16'($urandom)};
	endfunction

	task automatic random_stream();
		logic v0;
		logic v1;
		for (int n = 0; n < num_random_pairs; n++) begin
			v0 = ($urandom_range(0, 9) != 0);
			v1 = ($urandom_range(0, 9) != 0);
			send_pair(make_pair(v0, random_instr(), v1, random_instr()));
		end
		wait_drain();
	endtask

	initial begin
		rstn = 1'b0;
		i_pair = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		void'($urandom(seed));
		repeat (8) @(negedge clk);
		rstn = 1'b1;
		reset_state();
		alu_ops();
		dependent_chain();
		write_order();
		bubble_slots();
		random_stream();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input wire clk,
	input wire rstn,
	input issue_pkg::issue_t i_issue,
	output issue_pkg::wb_t o_wb
);

	logic [issue_pkg::data_w-1:0] a;
	logic [issue_pkg::data_w-1:0] b;
	logic [issue_pkg::data_w-1:0] result;

	assign a = i_issue.ds_val;
	assign b = i_issue.op2_val;

	always_comb begin
		case (i_issue.opcode)
			issue_pkg::op_add, issue_pkg::op_addi: result = a + b;
			issue_pkg::op_sub: result = a - b;
			issue_pkg::op_and: result = a & b;
			issue_pkg::op_or: result = a | b;
			issue_pkg::op_xor: result = a ^ b;
			issue_pkg::op_slt: result = {{(issue_pkg::data_w-1){1'b0}}, $signed(a) < $signed(b)};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_wb.valid <= 1'b0;
		end else begin
			o_wb.valid <= i_issue.valid;
			o_wb.addr <= i_issue.dd;
			o_wb.data <= result;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dual_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core (
	input wire clk,
	input wire rstn,
	input issue_pkg::fetch_pair_t i_pair,
	output logic o_busy,
	output issue_pkg::wb_t o_alu_wb,
	output issue_pkg::wb_t o_mul_wb
);

	issue_pkg::dec_op_t [1:0] dec_ops;
	issue_pkg::dec_op_t [issue_pkg::window_depth-1:0] entries;
	logic window_accept;
	logic [issue_pkg::window_depth-1:0] issued;
	logic [3:0][issue_pkg::reg_addr_w-1:0] rd_addr;
	logic [3:0][issue_pkg::data_w-1:0] rd_data;
	issue_pkg::issue_t alu_issue;
	issue_pkg::issue_t mul_issue;

	pair_decoder u_pair_decoder (
		.clk(clk), .rstn(rstn), .i_pair(i_pair), .i_window_accept(window_accept),
		.o_ops(dec_ops), .o_busy(o_busy)
	);

	wait_window u_wait_window (
		.clk(clk), .rstn(rstn), .i_ops(dec_ops), .i_issued(issued),
		.o_entries(entries), .o_accept(window_accept)
	);

	issue_scoreboard u_issue_scoreboard (
		.clk(clk), .rstn(rstn), .i_entries(entries), .i_alu_wb(o_alu_wb),
		.i_mul_wb(o_mul_wb), .o_issued(issued), .o_rd_addr(rd_addr),
		.i_rd_data(rd_data), .o_alu_issue(alu_issue), .o_mul_issue(mul_issue)
	);

	reg_file u_reg_file (
		.clk(clk), .rstn(rstn), .i_rd_addr(rd_addr), .o_rd_data(rd_data),
		.i_alu_wb(o_alu_wb), .i_mul_wb(o_mul_wb)
	);

	alu_unit u_alu_unit (.clk(clk), .rstn(rstn), .i_issue(alu_issue), .o_wb(o_alu_wb));

	mul_unit u_mul_unit (.clk(clk), .rstn(rstn), .i_issue(mul_issue), .o_wb(o_mul_wb));

endmodule

`default_nettype wire

// ==== verilog/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

	localparam int reg_addr_w = 5;
	localparam int data_w = 32;
	localparam int instr_w = 32;
	localparam int window_depth = 3;
	localparam int mul_stages = 3;

	// opcode values in bits 31:26
	localparam logic [5:0] op_add = 6'h01;
	localparam logic [5:0] op_sub = 6'h02;
	localparam logic [5:0] op_and = 6'h03;
	localparam logic [5:0] op_or = 6'h04;
	localparam logic [5:0] op_xor = 6'h05;
	localparam logic [5:0] op_slt = 6'h06;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_mul = 6'h10;

	typedef enum logic {
		unit_alu = 1'b0,
		unit_mul = 1'b1
	} unit_e;

	// slot 0 is the older instruction
	typedef struct packed {
		logic [1:0] slot_valid;
		logic [1:0][instr_w-1:0] instr;
	} fetch_pair_t;

	typedef struct packed {
		logic valid;
		logic [5:0] opcode;
		unit_e unit;
		logic [reg_addr_w-1:0] ds;
		logic [reg_addr_w-1:0] dt;
		logic [reg_addr_w-1:0] dd;
		logic uses_dt;
		logic [data_w-1:0] imm;
	} dec_op_t;

	typedef struct packed {
		logic valid;
		logic [5:0] opcode;
		logic [reg_addr_w-1:0] dd;
		logic [data_w-1:0] ds_val;
		logic [data_w-1:0] op2_val;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [reg_addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

// ==== verilog/issue_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_scoreboard (
	input wire clk,
	input wire rstn,
	input issue_pkg::dec_op_t [issue_pkg::window_depth-1:0] i_entries,
	input issue_pkg::wb_t i_alu_wb,
	input issue_pkg::wb_t i_mul_wb,
	output logic [issue_pkg::window_depth-1:0] o_issued,
	output logic [3:0][issue_pkg::reg_addr_w-1:0] o_rd_addr,
	input wire [3:0][issue_pkg::data_w-1:0] i_rd_data,
	output issue_pkg::issue_t o_alu_issue,
	output issue_pkg::issue_t o_mul_issue
);

	logic [(1 << issue_pkg::reg_addr_w)-1:0] busy;
	logic [(1 << issue_pkg::reg_addr_w)-1:0] clr_mask;
	logic [(1 << issue_pkg::reg_addr_w)-1:0] set_mask;
	logic [(1 << issue_pkg::reg_addr_w)-1:0] busy_now;
	logic [issue_pkg::window_depth-1:0] eligible;
	logic [issue_pkg::window_depth-1:0] alu_sel;
	logic [issue_pkg::window_depth-1:0] mul_sel;
	issue_pkg::dec_op_t alu_op;
	issue_pkg::dec_op_t mul_op;

	always_comb begin
		clr_mask = '0;
		if (i_alu_wb.valid) clr_mask[i_alu_wb.addr] = 1'b1;
		if (i_mul_wb.valid) clr_mask[i_mul_wb.addr] = 1'b1;
	end

	// a register written back this cycle is forwarded, so it counts as free
	assign busy_now = busy & ~clr_mask;

	always_comb begin
		issue_pkg::dec_op_t e;
		issue_pkg::dec_op_t o;
		logic hazard;
		for (int i = 0; i < issue_pkg::window_depth; i++) begin
			e = i_entries[i];
			hazard = busy_now[e.ds] | (e.uses_dt & busy_now[e.dt]) | busy_now[e.dd];
			for (int j = 0; j < i; j++) begin
				o = i_entries[j];
				if (o.valid) begin
					// raw on an older destination
					if (o.dd == e.ds || (e.uses_dt && o.dd == e.dt)) hazard = 1'b1;
					// war and waw
					if (e.dd == o.ds || (o.uses_dt && e.dd == o.dt) || e.dd == o.dd)
						hazard = 1'b1;
				end
			end
			eligible[i] = e.valid & ~hazard;
		end
	end

	// oldest eligible entry per unit
	always_comb begin
		alu_sel = '0;
		mul_sel = '0;
		alu_op = '0;
		mul_op = '0;
		for (int i = 0; i < issue_pkg::window_depth; i++) begin
			if (eligible[i] && i_entries[i].unit == issue_pkg::unit_alu && alu_sel == '0) begin
				alu_sel[i] = 1'b1;
				alu_op = i_entries[i];
			end
			if (eligible[i] && i_entries[i].unit == issue_pkg::unit_mul && mul_sel == '0) begin
				mul_sel[i] = 1'b1;
				mul_op = i_entries[i];
			end
		end
	end

	assign o_issued = alu_sel | mul_sel;

	assign o_rd_addr[0] = alu_op.ds;
	assign o_rd_addr[1] = alu_op.dt;
	assign o_rd_addr[2] = mul_op.ds;
	assign o_rd_addr[3] = mul_op.dt;

	always_comb begin
		o_alu_issue.valid = alu_op.valid;
		o_alu_issue.opcode = alu_op.opcode;
		o_alu_issue.dd = alu_op.dd;
		o_alu_issue.ds_val = i_rd_data[0];
		o_alu_issue.op2_val = alu_op.uses_dt ? i_rd_data[1] : alu_op.imm;
		o_mul_issue.valid = mul_op.valid;
		o_mul_issue.opcode = mul_op.opcode;
		o_mul_issue.dd = mul_op.dd;
		o_mul_issue.ds_val = i_rd_data[2];
		o_mul_issue.op2_val = mul_op.uses_dt ? i_rd_data[3] : mul_op.imm;
	end

	always_comb begin
		set_mask = '0;
		if (alu_op.valid) set_mask[alu_op.dd] = 1'b1;
		if (mul_op.valid) set_mask[mul_op.dd] = 1'b1;
		// r0 stays free
		set_mask[0] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			busy <= busy_now | set_mask;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input wire clk,
	input wire rstn,
	input issue_pkg::issue_t i_issue,
	output issue_pkg::wb_t o_wb
);

	typedef struct packed {
		logic valid;
		logic [issue_pkg::reg_addr_w-1:0] dd;
		logic [issue_pkg::data_w-1:0] lo;
		logic [issue_pkg::data_w-1:0] hi;
	} mul_stage_t;

	mul_stage_t stage [issue_pkg::mul_stages];
	logic [issue_pkg::data_w+issue_pkg::data_w/2-1:0] prod_lo;
	logic [issue_pkg::data_w-1:0] prod_hi;

	// only the low word is kept, so a[31:16]*b[31:16] never matters
	assign prod_lo = i_issue.ds_val * i_issue.op2_val[issue_pkg::data_w/2-1:0];
	assign prod_hi = i_issue.ds_val[issue_pkg::data_w/2-1:0]
		* i_issue.op2_val[issue_pkg::data_w-1:issue_pkg::data_w/2];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int k = 0; k < issue_pkg::mul_stages; k++) begin
				stage[k].valid <= 1'b0;
			end
		end else begin
			stage[0].valid <= i_issue.valid;
			stage[0].dd <= i_issue.dd;
			stage[0].lo <= prod_lo[issue_pkg::data_w-1:0];
			stage[0].hi <= {prod_hi[issue_pkg::data_w/2-1:0], {(issue_pkg::data_w/2){1'b0}}};
			// both partials ride the pipeline and merge at the output
			for (int k = 1; k < issue_pkg::mul_stages; k++) begin
				stage[k].valid <= stage[k-1].valid;
				stage[k].dd <= stage[k-1].dd;
				stage[k].lo <= stage[k-1].lo;
				stage[k].hi <= stage[k-1].hi;
			end
		end
	end

	assign o_wb.valid = stage[issue_pkg::mul_stages-1].valid;
	assign o_wb.addr = stage[issue_pkg::mul_stages-1].dd;
	assign o_wb.data = stage[issue_pkg::mul_stages-1].lo + stage[issue_pkg::mul_stages-1].hi;

endmodule

`default_nettype wire

// ==== verilog/pair_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_decoder (
	input wire clk,
	input wire rstn,
	input issue_pkg::fetch_pair_t i_pair,
	input wire i_window_accept,
	output issue_pkg::dec_op_t [1:0] o_ops,
	output logic o_busy
);

	issue_pkg::fetch_pair_t pair_q;
	logic full;

	function automatic issue_pkg::dec_op_t decode_slot(
		input logic [issue_pkg::instr_w-1:0] instr,
		input logic slot_valid
	);
		issue_pkg::dec_op_t d;
		logic known;
		d.opcode = instr[31:26];
		d.dd = instr[25:21];
		d.ds = instr[20:16];
		d.dt = instr[15:11];
		d.imm = {{16{instr[15]}}, instr[15:0]};
		d.unit = issue_pkg::unit_alu;
		d.uses_dt = 1'b1;
		known = 1'b1;
		case (d.opcode)
			issue_pkg::op_add, issue_pkg::op_sub, issue_pkg::op_and,
			issue_pkg::op_or, issue_pkg::op_xor, issue_pkg::op_slt: known = 1'b1;
			issue_pkg::op_addi: d.uses_dt = 1'b0;
			issue_pkg::op_mul: d.unit = issue_pkg::unit_mul;
			default: known = 1'b0;
		endcase
		// writes to r0 are dropped here as bubbles
		d.valid = slot_valid && known && (d.dd != '0);
		return d;
	endfunction

	always_comb begin
		o_ops[0] = decode_slot(pair_q.instr[0], pair_q.slot_valid[0]);
		o_ops[1] = decode_slot(pair_q.instr[1], pair_q.slot_valid[1]);
	end

	assign full = o_ops[0].valid | o_ops[1].valid;
	assign o_busy = full & ~i_window_accept;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pair_q.slot_valid <= '0;
		end else if (!o_busy) begin
			pair_q <= i_pair;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input wire clk,
	input wire rstn,
	input wire [3:0][issue_pkg::reg_addr_w-1:0] i_rd_addr,
	output logic [3:0][issue_pkg::data_w-1:0] o_rd_data,
	input issue_pkg::wb_t i_alu_wb,
	input issue_pkg::wb_t i_mul_wb
);

	logic [issue_pkg::data_w-1:0] regs [(1 << issue_pkg::reg_addr_w)];

	// r0 reads zero and a same-cycle write-back is bypassed
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			if (i_rd_addr[p] == '0) begin
				o_rd_data[p] = '0;
			end else if (i_alu_wb.valid && i_alu_wb.addr == i_rd_addr[p]) begin
				o_rd_data[p] = i_alu_wb.data;
			end else if (i_mul_wb.valid && i_mul_wb.addr == i_rd_addr[p]) begin
				o_rd_data[p] = i_mul_wb.data;
			end else begin
				o_rd_data[p] = regs[i_rd_addr[p]];
			end
		end
	end

	// at most one write in flight per register, so the two ports never collide
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < (1 << issue_pkg::reg_addr_w); i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (i_alu_wb.valid && i_alu_wb.addr != '0) begin
				regs[i_alu_wb.addr] <= i_alu_wb.data;
			end
			if (i_mul_wb.valid && i_mul_wb.addr != '0) begin
				regs[i_mul_wb.addr] <= i_mul_wb.data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/wait_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module wait_window (
	input wire clk,
	input wire rstn,
	input issue_pkg::dec_op_t [1:0] i_ops,
	input wire [issue_pkg::window_depth-1:0] i_issued,
	output issue_pkg::dec_op_t [issue_pkg::window_depth-1:0] o_entries,
	output logic o_accept
);

	issue_pkg::dec_op_t [issue_pkg::window_depth-1:0] entries_q;
	issue_pkg::dec_op_t [issue_pkg::window_depth-1:0] entries_d;
	logic [issue_pkg::window_depth-1:0] remain;
	logic [1:0] n_remain;

	assign o_entries = entries_q;

	// entries still waiting once this cycle's issue is gone
	always_comb begin
		n_remain = '0;
		for (int i = 0; i < issue_pkg::window_depth; i++) begin
			remain[i] = entries_q[i].valid & ~i_issued[i];
			n_remain = n_remain + {1'b0, remain[i]};
		end
	end

	// room for a whole pair
	assign o_accept = (n_remain <= 2'd1);

	always_comb begin
		int k;
		k = 0;
		entries_d = '0;
		// compact toward entry 0 in age order
		for (int i = 0; i < issue_pkg::window_depth; i++) begin
			if (remain[i]) begin
				entries_d[k] = entries_q[i];
				k = k + 1;
			end
		end
		if (o_accept) begin
			for (int s = 0; s < 2; s++) begin
				if (i_ops[s].valid) begin
					entries_d[k] = i_ops[s];
					k = k + 1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < issue_pkg::window_depth; i++) begin
				entries_q[i].valid <= 1'b0;
			end
		end else begin
			entries_q <= entries_d;
		end
	end

endmodule

`default_nettype wire
